//--- flist.f
common/audio_pkg.sv
common/cmd_pkg.sv
verilog/sample_delay.sv
cmd/cmd_regs.sv
fx/echo_cancel.sv
fx/voice_change.sv
verilog/audio_out_stage.sv
verilog/voice_top.sv
dv/voice_checker.sv
dv/voice_tb.sv

//--- dv/voice_tb.sv
// testbench for voice_top, random samples in segments of one command byte
// a cycle model predicts o_sample and o_voice_flag, checked on falling edges
`timescale 1ns/1ps

module voice_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int SEG_LEN      = 200;
  localparam int NUM_SEG      = 10;
  localparam int SKIP         = 6;                // settle cycles after a command change
  localparam int TOTAL        = NUM_SEG * SEG_LEN;

  logic               es1_dlrc;
  logic               sys_rst;
  audio_pkg::sample_t i_sample;
  cmd_pkg::cmd_t      i_cmd_data;
  audio_pkg::sample_t o_sample;
  logic               o_voice_flag;

  // pass, echo, deep, bright, echo, deep, unknown, echo, bright, unknown
  cmd_pkg::cmd_t seg_cmd [NUM_SEG] = '{8'h00, 8'h10, 8'h20, 8'h21, 8'h10,
                                       8'h20, 8'h45, 8'h10, 8'h2f, 8'hf3};

  int            x_hist    [TOTAL];               // sample driven at each step
  cmd_pkg::cmd_t cmd_hist  [TOTAL];
  bit            mode_hist [TOTAL];               // vc_mode after that step's byte

  voice_top UUT (
    .es1_dlrc     (es1_dlrc),
    .sys_rst      (sys_rst),
    .i_sample     (i_sample),
    .i_cmd_data   (i_cmd_data),
    .o_sample     (o_sample),
    .o_voice_flag (o_voice_flag)
  );

  initial es1_dlrc = 1'b0;
  always #(CLK_PERIOD / 2) es1_dlrc = ~es1_dlrc;

  function automatic int past_sample(int n);
    if (n < 0) return 0;                          // before reset counts as silence
    return x_hist[n];
  endfunction

  function automatic cmd_pkg::cmd_t past_cmd(int n);
    if (n < 0) return 8'h00;
    return cmd_hist[n];
  endfunction

  function automatic bit past_mode(int n);
    if (n < 0) return 1'b0;
    return mode_hist[n];
  endfunction

  function automatic int clamp(int v);
    if (v > 32767) return 32767;
    if (v < -32768) return -32768;
    return v;
  endfunction

  // 0 pass, 1 echo, 2 voice change
  function automatic int effect_code(cmd_pkg::cmd_t c);
    if (c[7:4] == cmd_pkg::CMD_ECHO) return 1;
    if (c[7:4] == cmd_pkg::CMD_CHANGE) return 2;
    return 0;
  endfunction

  function automatic string test_name(cmd_pkg::cmd_t c);
    case (effect_code(c))
      1:       return "echo";
      2:       return c[0] ? "bright" : "deep";
      default: return "pass";
    endcase
  endfunction

  // output seen two steps after sample n went in
  function automatic int expected_sample(int n);
    int x0;
    int x1;
    int x8;
    x0 = past_sample(n);
    x1 = past_sample(n - 1);
    x8 = past_sample(n - audio_pkg::ECHO_DELAY);
    case (effect_code(past_cmd(n - 2)))          // select register sees byte n-2
      1: return clamp(x0 - (x8 >>> 1));
      2: begin
        if (past_mode(n - 3)) return clamp(x0 - x1);  // filter ran one edge earlier
        return (x0 + x1) >>> 1;
      end
      default: return x0;
    endcase
  endfunction

  function automatic bit expected_flag(int n);
    int x0;
    x0 = past_sample(n);
    if (x0 < 0) x0 = -x0;
    return x0 > audio_pkg::VOICE_THRESHOLD;
  endfunction

  // about one in eight is full scale, some sit right at the threshold
  function automatic int random_sample();
    int sel;
    sel = $urandom % 16;
    case (sel)
      0:          return 32767;
      1:          return -32768;
      2:          return ($urandom % 2) ? 2000 : -2000;
      3:          return ($urandom % 2) ? 2001 : -2001;
      4, 5, 6, 7: return int'($urandom % 8192) - 4096;
      default:    return int'($urandom % 65536) - 32768;
    endcase
  endfunction

  task automatic check_zero(string name);
    assert (o_sample === '0) else begin
      $display("** Error %s: o_sample expected 0, actual %0d", name, o_sample);
      $display("TESTBENCH FAILED");
      $fatal(1, "o_sample not cleared");
    end
    assert (o_voice_flag === 1'b0) else begin
      $display("** Error %s: o_voice_flag expected 0, actual %b", name, o_voice_flag);
      $display("TESTBENCH FAILED");
      $fatal(1, "o_voice_flag not cleared");
    end
  endtask

  task automatic check_output(int n);
    int    exp_s;
    bit    exp_f;
    string name;
    exp_s = expected_sample(n);
    exp_f = expected_flag(n);
    name  = test_name(seg_cmd[n / SEG_LEN]);
    assert (o_sample === audio_pkg::sample_t'(exp_s)) else begin
      $display("** Error %s, sample %0d: o_sample expected %0d, actual %0d",
               name, n, exp_s, o_sample);
      $display("TESTBENCH FAILED");
      $fatal(1, "o_sample mismatch");
    end
    assert (o_voice_flag === exp_f) else begin
      $display("** Error voice_flag (%s), sample %0d: expected %b, actual %b",
               name, n, exp_f, o_voice_flag);
      $display("TESTBENCH FAILED");
      $fatal(1, "o_voice_flag mismatch");
    end
  endtask

  initial begin
    void'($urandom(21));
    sys_rst    = 1'b0;
    i_sample   = '0;
    i_cmd_data = 8'h00;
    repeat (RESET_CYCLES) begin
      @(negedge es1_dlrc);
      check_zero("reset");
    end
    sys_rst = 1'b1;                               // release on a falling edge
    for (int m = 0; m < TOTAL + 2; m++) begin
      if (m < 2) begin
        check_zero("after reset");
      end else if (((m - 2) % SEG_LEN) >= SKIP) begin
        check_output(m - 2);
      end
      if (m < TOTAL) begin
        x_hist[m]   = random_sample();
        cmd_hist[m] = seg_cmd[m / SEG_LEN];
        if (cmd_hist[m][7:4] == cmd_pkg::CMD_CHANGE) begin
          mode_hist[m] = cmd_hist[m][0];
        end else begin
          mode_hist[m] = past_mode(m - 1);        // mode held across other bytes
        end
        i_sample   = audio_pkg::sample_t'(x_hist[m]);
        i_cmd_data = cmd_hist[m];
      end
      @(negedge es1_dlrc);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    #((NUM_SEG * SEG_LEN + 100) * CLK_PERIOD);
    $display("run hung, the watchdog expired before all segments were done");
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

//--- dv/voice_checker.sv
// concurrent checks on the voice_top outputs
// bound into voice_top below, so every instance carries them
`timescale 1ns/1ps

module voice_checker (
  input logic               es1_dlrc,
  input logic               sys_rst,
  input audio_pkg::sample_t i_out_sample,
  input logic               i_voice_flag
);

  // sampled on the falling edge, away from the output registers
  reset_outputs_zero: assert property (@(negedge es1_dlrc)
    !sys_rst |-> (i_out_sample == '0 && !i_voice_flag))
    else $error("outputs not cleared while reset is asserted");

  outputs_known: assert property (@(posedge es1_dlrc) disable iff (!sys_rst)
    !$isunknown({i_out_sample, i_voice_flag}))
    else $error("output unknown after reset");

endmodule

bind voice_top voice_checker u_voice_checker (
  .es1_dlrc     (es1_dlrc),
  .sys_rst      (sys_rst),
  .i_out_sample (o_sample),
  .i_voice_flag (o_voice_flag)
);

//--- verilog/voice_top.sv
// sample-rate voice path: command decode, echo cancelling, voice change
// and output select, one sample in and one out per LRCK edge
`timescale 1ns/1ps

module voice_top (
  input  logic               es1_dlrc,      // LRCK, one sample per rising edge
  input  logic               sys_rst,
  input  audio_pkg::sample_t i_sample,
  input  cmd_pkg::cmd_t      i_cmd_data,    // held from the UART side
  output audio_pkg::sample_t o_sample,
  output logic               o_voice_flag
);

  cmd_pkg::fx_cfg_t   cfg;
  audio_pkg::sample_t echo_sample;
  audio_pkg::sample_t change_sample;

  cmd_regs u_cmd_regs (
    .es1_dlrc   (es1_dlrc),
    .sys_rst    (sys_rst),
    .i_cmd_data (i_cmd_data),
    .o_cfg      (cfg)
  );

  echo_cancel u_echo_cancel (
    .es1_dlrc (es1_dlrc),
    .sys_rst  (sys_rst),
    .i_sample (i_sample),
    .o_sample (echo_sample)
  );

  voice_change u_voice_change (
    .es1_dlrc (es1_dlrc),
    .sys_rst  (sys_rst),
    .i_sample (i_sample),
    .i_cfg    (cfg),
    .o_sample (change_sample)
  );

  audio_out_stage u_out_stage (
    .es1_dlrc     (es1_dlrc),
    .sys_rst      (sys_rst),
    .i_dry        (i_sample),
    .i_echo       (echo_sample),
    .i_change     (change_sample),
    .i_cfg        (cfg),
    .o_sample     (o_sample),
    .o_voice_flag (o_voice_flag)
  );

endmodule

//--- verilog/audio_out_stage.sv
// aligns the dry sample with the effect results, picks the output sample
// by the current effect and raises the voice flag on loud input
`timescale 1ns/1ps

module audio_out_stage (
  input  logic               es1_dlrc,
  input  logic               sys_rst,
  input  audio_pkg::sample_t i_dry,
  input  audio_pkg::sample_t i_echo,
  input  audio_pkg::sample_t i_change,
  input  cmd_pkg::fx_cfg_t   i_cfg,
  output audio_pkg::sample_t o_sample,
  output logic               o_voice_flag
);

  audio_pkg::sample_t                  dry_q;    // same age as the effect results
  logic signed [audio_pkg::SAMPLE_W:0] dry_w;
  logic signed [audio_pkg::SAMPLE_W:0] mag_w;
  audio_pkg::sample_t                  sel_sample;

  assign dry_w = dry_q;
  assign mag_w = dry_w[audio_pkg::SAMPLE_W] ? -dry_w : dry_w;  // -32768 gives 32768

  always_comb begin
    case (i_cfg.effect)
      cmd_pkg::FX_ECHO:   sel_sample = i_echo;
      cmd_pkg::FX_CHANGE: sel_sample = i_change;
      default:            sel_sample = dry_q;
    endcase
  end

  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      dry_q        <= '0;
      o_sample     <= '0;
      o_voice_flag <= 1'b0;
    end else begin
      dry_q        <= i_dry;
      o_sample     <= sel_sample;
      o_voice_flag <= (mag_w > audio_pkg::VOICE_THRESHOLD);  // strictly above
    end
  end

endmodule

//--- fx/voice_change.sv
// voice colouring from the current and the previous sample
// deep mode averages the pair, bright mode takes the clamped difference
`timescale 1ns/1ps

module voice_change (
  input  logic               es1_dlrc,
  input  logic               sys_rst,
  input  audio_pkg::sample_t i_sample,
  input  cmd_pkg::fx_cfg_t   i_cfg,
  output audio_pkg::sample_t o_sample
);

  audio_pkg::sample_t                  prev_q;   // x[n-1]
  logic signed [audio_pkg::SAMPLE_W:0] sum_w;
  logic signed [audio_pkg::SAMPLE_W:0] avg_w;
  logic signed [audio_pkg::SAMPLE_W:0] diff_w;

  assign sum_w  = i_sample + prev_q;
  assign avg_w  = sum_w >>> 1;                  // always back in sample range
  assign diff_w = i_sample - prev_q;

  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      prev_q   <= '0;
      o_sample <= '0;
    end else begin
      prev_q <= i_sample;
      if (i_cfg.vc_mode) begin
        o_sample <= audio_pkg::saturate(diff_w);  // bright
      end else begin
        o_sample <= avg_w[audio_pkg::SAMPLE_W-1:0];  // deep
      end
    end
  end

endmodule

//--- fx/echo_cancel.sv
// cancels a fixed echo by subtracting half of the sample ECHO_DELAY back
// result is saturated and registered one edge after the input sample
`timescale 1ns/1ps

module echo_cancel (
  input  logic               es1_dlrc,
  input  logic               sys_rst,
  input  audio_pkg::sample_t i_sample,
  output audio_pkg::sample_t o_sample
);

  audio_pkg::sample_t                  delayed;
  audio_pkg::sample_t                  half_echo;
  logic signed [audio_pkg::SAMPLE_W:0] diff_w;

  // history of past samples, zero before the first real one
  sample_delay #(
    .T     (audio_pkg::sample_t),
    .DEPTH (audio_pkg::ECHO_DELAY)
  ) u_echo_line (
    .es1_dlrc (es1_dlrc),
    .sys_rst  (sys_rst),
    .i_data   (i_sample),
    .o_data   (delayed)                     // x[n - ECHO_DELAY]
  );

  assign half_echo = delayed >>> 1;         // arithmetic, keeps the sign
  assign diff_w    = i_sample - half_echo;  // 17 bit, cannot wrap

  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      o_sample <= '0;
    end else begin
      o_sample <= audio_pkg::saturate(diff_w);
    end
  end

endmodule

//--- cmd/cmd_regs.sv
// brings the level-held command byte into the LRCK domain and decodes it
// into the effect setup, three edges after a change of i_cmd_data
`timescale 1ns/1ps

module cmd_regs (
  input  logic             es1_dlrc,
  input  logic             sys_rst,
  input  cmd_pkg::cmd_t    i_cmd_data,
  output cmd_pkg::fx_cfg_t o_cfg
);

  cmd_pkg::cmd_t    cmd_sync;
  cmd_pkg::effect_e fx_next;

  // two-flop synchronizer for the whole byte
  sample_delay #(
    .T     (cmd_pkg::cmd_t),
    .DEPTH (2)
  ) u_cmd_sync (
    .es1_dlrc (es1_dlrc),
    .sys_rst  (sys_rst),
    .i_data   (i_cmd_data),
    .o_data   (cmd_sync)
  );

  always_comb begin
    case (cmd_sync[7:4])
      cmd_pkg::CMD_ECHO:   fx_next = cmd_pkg::FX_ECHO;
      cmd_pkg::CMD_CHANGE: fx_next = cmd_pkg::FX_CHANGE;
      default:             fx_next = cmd_pkg::FX_PASS;   // unknown codes pass through
    endcase
  end

  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      o_cfg.effect  <= cmd_pkg::FX_PASS;
      o_cfg.vc_mode <= 1'b0;
    end else begin
      o_cfg.effect <= fx_next;
      if (cmd_sync[7:4] == cmd_pkg::CMD_CHANGE) begin
        o_cfg.vc_mode <= cmd_sync[cmd_pkg::VC_MODE_BIT];  // kept across other cmds
      end
    end
  end

endmodule

//--- verilog/sample_delay.sv
// fixed-depth shift delay for any payload type, one stage per LRCK edge
// o_data is i_data from DEPTH edges earlier, all stages clear on reset
`timescale 1ns/1ps

module sample_delay #(
  parameter type T     = audio_pkg::sample_t,
  parameter int  DEPTH = 2
) (
  input  logic es1_dlrc,
  input  logic sys_rst,
  input  T     i_data,
  output T     o_data
);

  T stage_q [DEPTH];

  always_ff @(posedge es1_dlrc or negedge sys_rst) begin
    if (!sys_rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= i_data;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];                 // shift toward the tail
      end
    end
  end

  assign o_data = stage_q[DEPTH-1];

endmodule

//--- common/cmd_pkg.sv
// command byte coding from the UART side and the decoded effect setup
// cmd_regs builds fx_cfg_t, the effects and the output stage read it
package cmd_pkg;

  typedef logic [7:0] cmd_t;                  // raw command byte

  localparam logic [3:0] CMD_ECHO   = 4'b0001; // upper nibble, echo cancelling
  localparam logic [3:0] CMD_CHANGE = 4'b0010; // upper nibble, voice change

  localparam int VC_MODE_BIT = 0;             // mode bit inside a change command

  typedef enum logic [1:0] {
    FX_PASS   = 2'd0,
    FX_ECHO   = 2'd1,
    FX_CHANGE = 2'd2
  } effect_e;

  // 3 bits: selected treatment plus the voice change flavour
  typedef struct packed {
    effect_e effect;
    logic    vc_mode;                          // 0 deep, 1 bright
  } fx_cfg_t;

endpackage

//--- common/audio_pkg.sv
// audio sample format and the constants of the sample-rate effects
// shared by every RTL block on the LRCK path, referenced as audio_pkg::name
package audio_pkg;

  localparam int SAMPLE_W = 16;                // bits per audio sample

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  localparam int ECHO_DELAY      = 8;          // echo distance in samples
  localparam int VOICE_THRESHOLD = 2000;       // voice flag level

  localparam sample_t SAMPLE_MAX = 16'sh7fff;  // +32767
  localparam sample_t SAMPLE_MIN = 16'sh8000;  // -32768

  // clamp a one-bit-wider result back into the sample range
  function automatic sample_t saturate(input logic signed [SAMPLE_W:0] value);
    if (value > SAMPLE_MAX) begin
      return SAMPLE_MAX;
    end else if (value < SAMPLE_MIN) begin
      return SAMPLE_MIN;
    end
    return value[SAMPLE_W-1:0];
  endfunction

endpackage
